// File: logic/quarkSettings.svh
// Build settings for the multicycle RV32I core
// Word and address width are fixed at 32 bits
// The register count must stay 32 for RV32I
// The reset address should be word aligned

`ifndef QUARK_SETTINGS_SVH
`define QUARK_SETTINGS_SVH

// First fetch address after reset
`define QUARK_RESET_ADDR 32'h0000_0000

`define QUARK_XLEN       32  // Data and address width
`define QUARK_REG_COUNT  32  // Integer registers x0..x31

`endif

// File: logic/quarkPkg.sv
// Shared types of the multicycle RV32I core
// Class codes follow instruction bits 6 to 2 of the base opcodes
// Any other opcode maps to opOther and is executed as a no-op

`default_nettype none

`include "quarkSettings.svh"

package quarkPkg;

   // Opcode classes, value is instr[6:2]
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011,
      opOther  = 5'b11111
   } opClass_t;

   // Sequencer states, one-hot
   typedef enum logic [7:0] {
      fetchInstr   = 8'b0000_0001,
      waitInstr    = 8'b0000_0010,
      fetchRegs    = 8'b0000_0100,
      aluStart     = 8'b0000_1000,
      execute      = 8'b0001_0000,
      loadState    = 8'b0010_0000,
      storeState   = 8'b0100_0000,
      waitAluOrMem = 8'b1000_0000
   } ctrlState_t;

   typedef struct packed {
      opClass_t               opClass;
      logic [4:0]             rd;
      logic [4:0]             rs1;
      logic [4:0]             rs2;
      logic [2:0]             funct3;
      logic                   altBit;   // instr[30]
      logic                   regForm;  // instr[5]
      logic [`QUARK_XLEN-1:0] immI;
      logic [`QUARK_XLEN-1:0] immS;
      logic [`QUARK_XLEN-1:0] immB;
      logic [`QUARK_XLEN-1:0] immU;
      logic [`QUARK_XLEN-1:0] immJ;
   } decoded_t;

   typedef struct packed {
      logic [`QUARK_XLEN-1:0] addr;
      logic [`QUARK_XLEN-1:0] wdata;
      logic [3:0]             wmask;  // Byte enables, one cycle per store
      logic                   rstrb;  // Read pulse
   } memReq_t;

   typedef struct packed {
      logic [`QUARK_XLEN-1:0] sum;        // Operand 1 plus operand 2
      logic                   predicate;  // Latched branch condition
      logic                   busy;       // Shift still running
   } aluFlags_t;

endpackage

`default_nettype wire

// File: logic/quarkDecoder.sv
// Instruction latch and field decode
// Bits 1 and 0 of the instruction are dropped since RV32I ignores them
// Class and fields are valid from the cycle after instrLoad

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkDecoder (
   input  logic                   clk,
   input  logic                   instrLoad,
   input  logic [`QUARK_XLEN-1:0] memRdata,
   output quarkPkg::decoded_t     dec
);
   import quarkPkg::*;

   logic [31:2] instr;    // Latched instruction word
   opClass_t    opClass;  // Registered class

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata[31:2];
         case (memRdata[6:2])  // Same word that goes into instr
            5'b00000: opClass <= opLoad;
            5'b00100: opClass <= opAluImm;
            5'b00101: opClass <= opAuipc;
            5'b01000: opClass <= opStore;
            5'b01100: opClass <= opAluReg;
            5'b01101: opClass <= opLui;
            5'b11000: opClass <= opBranch;
            5'b11001: opClass <= opJalr;
            5'b11011: opClass <= opJal;
            default:  opClass <= opOther;  // SYSTEM, FENCE and unknown
         endcase
      end
   end

   // Fields and the five immediate formats
   always_comb begin
      dec.opClass = opClass;
      dec.rd      = instr[11:7];
      dec.rs1     = instr[19:15];
      dec.rs2     = instr[24:20];
      dec.funct3  = instr[14:12];
      dec.altBit  = instr[30];   // SUB and SRA select
      dec.regForm = instr[5];    // Register form of ALU ops
      dec.immI    = {{21{instr[31]}}, instr[30:20]};
      dec.immS    = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      dec.immB    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      dec.immU    = {instr[31:12], 12'b0};
      dec.immJ    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   end

endmodule

`default_nettype wire

// File: logic/quarkRegFile.sv
// Integer register file, two registered reads and one write per cycle
// Reads of x0 return zero and writes to x0 are dropped
// Read data lags the indices by one cycle

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkRegFile (
   input  logic                   clk,
   input  logic [4:0]             rs1,
   input  logic [4:0]             rs2,
   input  logic [4:0]             rd,
   input  logic                   regWrite,
   input  logic [`QUARK_XLEN-1:0] writeData,
   output logic [`QUARK_XLEN-1:0] rs1Data,
   output logic [`QUARK_XLEN-1:0] rs2Data
);

   logic [`QUARK_XLEN-1:0] regs [`QUARK_REG_COUNT];

   always_ff @(posedge clk) begin
      rs1Data <= (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads as zero
      rs2Data <= (rs2 == 5'd0) ? '0 : regs[rs2];
      if (regWrite && rd != 5'd0) begin
         regs[rd] <= writeData;
      end
   end

endmodule

`default_nettype wire

// File: logic/quarkAlu.sv
// ALU with registered result and latched branch predicate
// Shifts run one bit per cycle, busy stays high until the count is zero
// Operand 1 is always rs1, operand 2 depends on the opcode class
// Results are valid the cycle after aluStart, or once busy drops

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkAlu (
   input  logic                   clk,
   input  quarkPkg::decoded_t     dec,
   input  logic [`QUARK_XLEN-1:0] rs1Data,
   input  logic [`QUARK_XLEN-1:0] rs2Data,
   input  logic                   aluStart,
   output logic [`QUARK_XLEN-1:0] aluOut,
   output quarkPkg::aluFlags_t    flags
);
   import quarkPkg::*;

   logic [`QUARK_XLEN-1:0] opnd2;
   logic [`QUARK_XLEN-1:0] sum;
   logic [`QUARK_XLEN:0]   minus;   // 33 bits, top bit is the borrow
   logic                   eq;
   logic                   lt;
   logic                   ltu;
   logic [`QUARK_XLEN-1:0] aluReg;  // Result and shift register
   logic [4:0]             shamt;   // Remaining shift steps
   logic                   predicate;

   // Branches and reg-reg ops use rs2, stores use immS, the rest immI
   assign opnd2 = (dec.opClass == opAluReg || dec.opClass == opBranch) ? rs2Data :
                  (dec.opClass == opStore) ? dec.immS : dec.immI;

   assign sum   = rs1Data + opnd2;  // Also the load/store and JALR address
   assign minus = {1'b1, ~opnd2} + {1'b0, rs1Data} + 33'd1;
   assign ltu   = minus[`QUARK_XLEN];
   assign lt    = (rs1Data[31] ^ opnd2[31]) ? rs1Data[31] : minus[`QUARK_XLEN];
   assign eq    = (minus[`QUARK_XLEN-1:0] == '0);

   // ******************** Result register
   always_ff @(posedge clk) begin
      if (aluStart) begin
         case (dec.funct3)
            3'b000: aluReg <= (dec.altBit & dec.regForm) ? minus[`QUARK_XLEN-1:0] : sum;
            3'b010: aluReg <= {31'b0, lt};    // SLT
            3'b011: aluReg <= {31'b0, ltu};   // SLTU
            3'b100: aluReg <= rs1Data ^ opnd2;
            3'b110: aluReg <= rs1Data | opnd2;
            3'b111: aluReg <= rs1Data & opnd2;
            default: begin                    // SLL, SRL, SRA
               aluReg <= rs1Data;
               shamt  <= opnd2[4:0];
            end
         endcase
      end else if (shamt != 5'd0) begin
         // One step per cycle, SRA fills with the sign bit
         shamt  <= shamt - 5'd1;
         aluReg <= dec.funct3[2] ? {dec.altBit & aluReg[31], aluReg[31:1]} : aluReg << 1;
      end
   end

   // ******************** Branch predicate
   always_ff @(posedge clk) begin
      case (dec.funct3)
         3'b000:  predicate <= eq;    // BEQ
         3'b001:  predicate <= !eq;   // BNE
         3'b100:  predicate <= lt;    // BLT
         3'b101:  predicate <= !lt;   // BGE
         3'b110:  predicate <= ltu;   // BLTU
         3'b111:  predicate <= !ltu;  // BGEU
         default: predicate <= 1'b0;
      endcase
   end

   assign aluOut = aluReg;

   always_comb begin
      flags.sum       = sum;
      flags.predicate = predicate;
      flags.busy      = (shamt != 5'd0);
   end

endmodule

`default_nettype wire

// File: logic/quarkLoadStore.sv
// Byte lane logic for loads and stores
// Memory is word addressed, addrLow picks the byte or halfword lane
// Misaligned halfword and word accesses are not detected

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkLoadStore (
   input  quarkPkg::decoded_t     dec,
   input  logic [1:0]             addrLow,
   input  logic [`QUARK_XLEN-1:0] memRdata,
   input  logic [`QUARK_XLEN-1:0] rs2Data,
   output logic [`QUARK_XLEN-1:0] loadData,
   output logic [`QUARK_XLEN-1:0] storeData,
   output logic [3:0]             storeMask
);

   logic        byteAccess;  // funct3[1:0] is 00
   logic        halfAccess;  // funct3[1:0] is 01
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   // ******************** Load extraction
   assign loadHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);  // LBU/LHU

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} : memRdata;

   // ******************** Store lanes
   // Low data is copied into every lane it may land in
   assign storeData[7:0]   = rs2Data[7:0];
   assign storeData[15:8]  = addrLow[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign storeData[23:16] = addrLow[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign storeData[31:24] = addrLow[0] ? rs2Data[7:0] :
                             addrLow[1] ? rs2Data[15:8] : rs2Data[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow;                  // One-hot byte
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;      // Upper or lower pair
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

// File: logic/quarkControl.sv
// One-hot sequencer with program counter and memory address register
// Reset parks the sequencer in waitAluOrMem until both busy levels are low
// Every instruction ends with the rstrb pulse of the next fetch
// JALR clears bit 0 of its target

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkControl (
   input  logic                   clk,
   input  logic                   reset,
   input  quarkPkg::decoded_t     dec,
   input  quarkPkg::aluFlags_t    flags,
   input  logic [`QUARK_XLEN-1:0] aluOut,
   input  logic [`QUARK_XLEN-1:0] loadData,
   input  logic [`QUARK_XLEN-1:0] storeData,
   input  logic [3:0]             storeMask,
   input  logic                   memRbusy,
   input  logic                   memWbusy,
   output logic                   instrLoad,
   output logic                   aluStart,
   output logic                   regWrite,
   output logic [`QUARK_XLEN-1:0] writeData,
   output logic [1:0]             addrLow,
   output quarkPkg::memReq_t      memReq
);
   import quarkPkg::*;

   ctrlState_t             state;
   logic [`QUARK_XLEN-1:0] pc;
   logic [`QUARK_XLEN-1:0] addrReg;    // Drives the memory address
   logic [`QUARK_XLEN-1:0] pcPlus4;
   logic [`QUARK_XLEN-1:0] pcPlusImm;  // Branch, JAL and AUIPC target
   logic [`QUARK_XLEN-1:0] nextPc;
   logic                   isAlu;
   logic                   isMem;
   logic                   jumpToImm;
   logic                   wbArmed;    // Late write-back of a load or shift

   assign isAlu     = (dec.opClass == opAluImm) || (dec.opClass == opAluReg);
   assign isMem     = (dec.opClass == opLoad) || (dec.opClass == opStore);
   assign jumpToImm = (dec.opClass == opJal) || (dec.opClass == opBranch && flags.predicate);
   assign pcPlus4   = pc + 32'd4;
   assign pcPlusImm = pc + ((dec.opClass == opJal)   ? dec.immJ :
                            (dec.opClass == opAuipc) ? dec.immU : dec.immB);
   assign nextPc    = (dec.opClass == opJalr) ? {flags.sum[31:1], 1'b0} :
                      jumpToImm ? pcPlusImm : pcPlus4;

   // ******************** Strobes
   assign instrLoad = (state == waitInstr) && !memRbusy;
   assign aluStart  = (state == quarkPkg::aluStart) && isAlu;  // Only ALU classes start it
   assign regWrite  = !(dec.opClass == opBranch || dec.opClass == opStore) &&
                      (state == execute || (state == waitAluOrMem && wbArmed));
   assign addrLow   = addrReg[1:0];

   always_comb begin
      memReq.addr  = addrReg;
      memReq.wdata = storeData;
      memReq.wmask = (state == storeState) ? storeMask : 4'b0000;
      memReq.rstrb = (state == fetchInstr) || (state == loadState);
   end

   // Write-back source by class
   always_comb begin
      case (dec.opClass)
         opLui:              writeData = dec.immU;
         opAluImm, opAluReg: writeData = aluOut;
         opAuipc:            writeData = pcPlusImm;
         opJal, opJalr:      writeData = pcPlus4;   // Link value
         opLoad:             writeData = loadData;
         default:            writeData = '0;
      endcase
   end

   // ******************** Sequencer
   always_ff @(posedge clk) begin
      if (!reset) begin
         state   <= waitAluOrMem;
         pc      <= `QUARK_RESET_ADDR;
         wbArmed <= 1'b0;
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) state <= fetchRegs;  // Decoder latches here
            end
            fetchRegs:          state <= quarkPkg::aluStart;
            quarkPkg::aluStart: state <= execute;
            execute: begin
               pc      <= nextPc;
               addrReg <= isMem ? flags.sum : nextPc;
               wbArmed <= (dec.opClass == opLoad) || isAlu;
               if (dec.opClass == opStore)     state <= storeState;
               else if (dec.opClass == opLoad) state <= loadState;
               else if (isAlu && flags.busy)   state <= waitAluOrMem;  // Shift running
               else                            state <= fetchInstr;
            end
            loadState, storeState: state <= waitAluOrMem;
            waitAluOrMem: begin
               if (!flags.busy && !memRbusy && !memWbusy) begin
                  addrReg <= pc;
                  wbArmed <= 1'b0;
                  state   <= fetchInstr;
               end
            end
            default: state <= waitAluOrMem;  // Recover from an illegal code
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/quarkCore.sv
// Top level of the multicycle RV32I core
// Single memory port shared by instruction fetch and data access
// memRbusy and memWbusy are plain levels with no handshake
// Read data is taken in the first cycle after rstrb with memRbusy low

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkCore (
   input  logic                   clk,
   input  logic                   reset,
   output quarkPkg::memReq_t      memReq,
   input  logic [`QUARK_XLEN-1:0] memRdata,
   input  logic                   memRbusy,
   input  logic                   memWbusy
);
   import quarkPkg::*;

   decoded_t               dec;
   aluFlags_t              flags;
   logic                   instrLoad;
   logic                   aluStart;
   logic                   regWrite;
   logic [`QUARK_XLEN-1:0] writeData;
   logic [`QUARK_XLEN-1:0] rs1Data;
   logic [`QUARK_XLEN-1:0] rs2Data;
   logic [`QUARK_XLEN-1:0] aluOut;
   logic [`QUARK_XLEN-1:0] loadData;
   logic [`QUARK_XLEN-1:0] storeData;
   logic [3:0]             storeMask;
   logic [1:0]             addrLow;

   quarkDecoder i_quarkDecoder (
      .clk(clk), .instrLoad(instrLoad), .memRdata(memRdata), .dec(dec)
   );

   quarkRegFile i_quarkRegFile (
      .clk(clk), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd), .regWrite(regWrite),
      .writeData(writeData), .rs1Data(rs1Data), .rs2Data(rs2Data)
   );

   quarkAlu i_quarkAlu (
      .clk(clk), .dec(dec), .rs1Data(rs1Data), .rs2Data(rs2Data),
      .aluStart(aluStart), .aluOut(aluOut), .flags(flags)
   );

   quarkLoadStore i_quarkLoadStore (
      .dec(dec), .addrLow(addrLow), .memRdata(memRdata), .rs2Data(rs2Data),
      .loadData(loadData), .storeData(storeData), .storeMask(storeMask)
   );

   quarkControl i_quarkControl (
      .clk(clk), .reset(reset), .dec(dec), .flags(flags), .aluOut(aluOut),
      .loadData(loadData), .storeData(storeData), .storeMask(storeMask),
      .memRbusy(memRbusy), .memWbusy(memWbusy), .instrLoad(instrLoad),
      .aluStart(aluStart), .regWrite(regWrite), .writeData(writeData),
      .addrLow(addrLow), .memReq(memReq)
   );

endmodule

`default_nettype wire

// File: test/tbClock.sv
// Clock and power-on reset for the testbench
// 40 ns period, reset held low for the first 16 rising edges

`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   initial begin
      reset = 1'b0;            // Active low
      repeat (16) @(posedge clk);
      reset <= 1'b1;
   end

endmodule

`default_nettype wire

// File: test/quarkCoreTb.sv
// Testbench for the multicycle RV32I core
// Program image is assembled here and reloaded into memory on every reset
// Run 1 has quiet memory, run 2 random busy spans, same expected stores
// Results go to 0x380, byte lane tests to 0x300, program must end below 0x300

`timescale 1ns/1ps
`default_nettype none

`include "quarkSettings.svh"

module quarkCoreTb;
   import quarkPkg::*;

   localparam logic [31:0] opA = 32'hF0F0_1234;  // Negative operand in x1
   localparam logic [31:0] opB = 32'h0000_5A5A;  // Small positive operand in x2

   logic                   clk;
   logic                   porReset;
   logic                   holdReset;    // Second reset between runs
   logic                   coreReset;
   logic                   busyOn;
   memReq_t                memReq;
   logic [`QUARK_XLEN-1:0] memRdata = '0;
   logic                   memRbusy = 1'b0;
   logic                   memWbusy = 1'b0;
   logic [31:0]            mem   [256];  // 1 KiB, word addressed
   logic [31:0]            image [256];
   logic [31:0]            asmPc;        // Assembly pointer
   logic [31:0]            expAddr [$];
   logic [31:0]            expData [$];
   logic [3:0]             expMask [$];
   string                  expName [$];
   int                     checkIdx;     // Next expected store
   bit                     sawFetch;
   int                     valueErrors = 0;
   int                     storeErrors = 0;
   int                     timeouts = 0;

   assign coreReset = porReset && !holdReset;

   tbClock i_tbClock (.clk(clk), .reset(porReset));

   quarkCore i_quarkCore (
      .clk(clk), .reset(coreReset), .memReq(memReq), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   // ******************** Memory model
   always @(posedge clk) begin
      if (!coreReset) begin
         mem <= image;                           // Fresh program each run
      end else begin
         if (memReq.rstrb) memRdata <= mem[memReq.addr[9:2]];  // Data one cycle later
         for (int i = 0; i < 4; i++) begin
            if (memReq.wmask[i]) mem[memReq.addr[9:2]][8*i +: 8] <= memReq.wdata[8*i +: 8];
         end
      end
      memRbusy <= busyOn && ($urandom % 4 == 0);  // Random busy spans
      memWbusy <= busyOn && ($urandom % 4 == 0);
   end

   // ******************** Instruction encoders
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // ******************** Reference model
   // ALU result, branch marker (1 taken, 2 not), load value or store lanes
   function automatic logic [31:0] reference(input opClass_t cls, input logic [2:0] f3,
                                             input logic alt, input logic [31:0] a, b);
      logic [31:0] r;
      logic [15:0] h;
      logic [7:0]  y;
      logic        taken;
      r = '0;
      case (cls)
         opAluImm, opAluReg: begin
            case (f3)
               3'b000:  r = (alt && cls == opAluReg) ? a - b : a + b;
               3'b001:  r = a << b[4:0];
               3'b010:  r = {31'b0, $signed(a) < $signed(b)};
               3'b011:  r = {31'b0, a < b};
               3'b100:  r = a ^ b;
               3'b101:  r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
               3'b110:  r = a | b;
               default: r = a & b;
            endcase
         end
         opBranch: begin
            case (f3)
               3'b000:  taken = (a == b);
               3'b001:  taken = (a != b);
               3'b100:  taken = ($signed(a) < $signed(b));
               3'b101:  taken = ($signed(a) >= $signed(b));
               3'b110:  taken = (a < b);
               default: taken = (a >= b);
            endcase
            r = taken ? 32'd1 : 32'd2;
         end
         opLoad: begin                          // a is the memory word, b the address
            y = a[8*b[1:0] +: 8];
            h = b[1] ? a[31:16] : a[15:0];
            case (f3)
               3'b000:  r = {{24{y[7]}}, y};
               3'b001:  r = {{16{h[15]}}, h};
               3'b100:  r = {24'b0, y};
               3'b101:  r = {16'b0, h};
               default: r = a;
            endcase
         end
         opStore: begin                         // Data moved to its byte lane
            case (f3[1:0])
               2'b00:   r = {24'b0, a[7:0]} << (8 * b[1:0]);
               2'b01:   r = {16'b0, a[15:0]} << (16 * b[1]);
               default: r = a;
            endcase
         end
         default: r = '0;
      endcase
      return r;
   endfunction

   // ******************** Program assembly
   task automatic emit(input logic [31:0] instr);
      image[asmPc[9:2]] = instr;
      asmPc = asmPc + 32'd4;
   endtask

   task automatic expectStore(input string name, input logic [31:0] addr,
                              input logic [31:0] value, input logic [3:0] mask);
      expName.push_back(name);
      expAddr.push_back(addr);
      expData.push_back(value);
      expMask.push_back(mask);
   endtask

   task automatic storeResult(input string name, input logic [4:0] rs, input logic [31:0] value);
      emit(encS(12'h380, rs, 5'd0, 3'b010));   // SW rs, 0x380(x0)
      expectStore(name, 32'h380, value, 4'b1111);
   endtask

   task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] hi;
      hi = value + 32'h800;                     // Round for the signed ADDI
      emit(encU(hi[31:12], rd, 7'b0110111));
      emit(encI(value[11:0], rd, 3'b000, rd, 7'b0010011));
   endtask

   task automatic buildProgram();
      logic [31:0] base;
      logic [31:0] va;
      logic [31:0] vb;
      logic [4:0]  rsA;
      logic [4:0]  rsB;
      logic [4:0]  sh;
      logic [2:0]  f3;
      logic [1:0]  off;
      logic [11:0] imm;
      for (int i = 0; i < 256; i++) begin
         image[i] = '0;
      end
      expName.delete();
      expAddr.delete();
      expData.delete();
      expMask.delete();
      asmPc = `QUARK_RESET_ADDR;
      loadConst(5'd1, opA);
      loadConst(5'd2, opB);
      imm = 12'hFFB;                            // -5 for the immediate forms
      for (int f = 0; f < 8; f++) begin
         f3 = f[2:0];
         if (f3 != 3'b001 && f3 != 3'b101) begin
            emit(encI(imm, 5'd1, f3, 5'd3, 7'b0010011));
            storeResult($sformatf("alu imm f3=%0d", f3), 5'd3,
                        reference(opAluImm, f3, 1'b0, opA, {{20{imm[11]}}, imm}));
            emit(encR(7'b0000000, 5'd2, 5'd1, f3, 5'd3));
            storeResult($sformatf("alu reg f3=%0d", f3), 5'd3,
                        reference(opAluReg, f3, 1'b0, opA, opB));
         end
      end
      emit(encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3));
      storeResult("sub", 5'd3, reference(opAluReg, 3'b000, 1'b1, opA, opB));
      emit(encU(20'hABCDE, 5'd3, 7'b0110111));
      storeResult("lui", 5'd3, {20'hABCDE, 12'h000});
      base = asmPc;
      emit(encU(20'h12345, 5'd3, 7'b0010111));
      storeResult("auipc", 5'd3, base + {20'h12345, 12'h000});
      // Shifts, k picks SLLI, SRLI or SRAI
      for (int s = 0; s < 4; s++) begin
         sh = (s == 0) ? 5'd0 : (s == 1) ? 5'd1 : (s == 2) ? 5'd17 : 5'd31;
         for (int k = 0; k < 3; k++) begin
            f3  = (k == 0) ? 3'b001 : 3'b101;
            imm = {(k == 2) ? 7'b0100000 : 7'b0000000, sh};
            emit(encI(imm, 5'd1, f3, 5'd3, 7'b0010011));
            storeResult($sformatf("shift f3=%0d sra=%0d by %0d", f3, k == 2, sh), 5'd3,
                        reference(opAluImm, f3, k == 2, opA, {27'b0, sh}));
         end
      end
      // Branches over three operand pairs, both outcomes for every funct3
      for (int f = 0; f < 8; f++) begin
         f3 = f[2:0];
         if (f3 != 3'b010 && f3 != 3'b011) begin
            for (int p = 0; p < 3; p++) begin
               rsA = (p == 2) ? 5'd2 : 5'd1;    // x1,x1 then x1,x2 then x2,x1
               rsB = (p == 1) ? 5'd2 : 5'd1;
               va  = (rsA == 5'd1) ? opA : opB;
               vb  = (rsB == 5'd1) ? opA : opB;
               emit(encI(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011));  // Taken marker
               emit(encB(13'd8, rsB, rsA, f3));
               emit(encI(12'd2, 5'd0, 3'b000, 5'd3, 7'b0010011));  // Fall-through marker
               storeResult($sformatf("branch f3=%0d x%0d,x%0d", f3, rsA, rsB), 5'd3,
                           reference(opBranch, f3, 1'b0, va, vb));
            end
         end
      end
      base = asmPc;
      emit(encJ(21'd8, 5'd5));
      emit(encI(12'd0, 5'd0, 3'b000, 5'd5, 7'b0010011));  // Skipped
      storeResult("jal link", 5'd5, base + 32'd4);
      base = asmPc;
      emit(encU(20'h00000, 5'd6, 7'b0010111));             // x6 = own address
      emit(encI(12'd12, 5'd6, 3'b000, 5'd5, 7'b1100111));
      emit(encI(12'd0, 5'd0, 3'b000, 5'd5, 7'b0010011));  // Skipped
      storeResult("jalr link", 5'd5, base + 32'd8);
      // Stores at every aligned offset, the word store comes last
      for (int w = 0; w < 3; w++) begin
         for (int o = 0; o < 4; o += (1 << w)) begin
            off = o[1:0];
            emit(encS(12'h300 | {10'b0, off}, 5'd1, 5'd0, {1'b0, w[1:0]}));
            expectStore($sformatf("store size=%0d offset=%0d", 1 << w, o),
                        32'h300 | {30'b0, off},
                        reference(opStore, {1'b0, w[1:0]}, 1'b0, opA, {30'b0, off}),
                        (w == 0) ? 4'b0001 << off : (w == 1) ? 4'b0011 << off : 4'b1111);
         end
      end
      // Loads read back the word opA at 0x300
      for (int w = 0; w < 3; w++) begin
         for (int u = 0; u < 2; u++) begin
            for (int o = 0; o < 4; o += (1 << w)) begin
               if (w < 2 || u == 0) begin
                  off = o[1:0];
                  f3  = {u[0], w[1:0]};
                  emit(encI(12'h300 | {10'b0, off}, 5'd0, f3, 5'd3, 7'b0000011));
                  storeResult($sformatf("load f3=%0d offset=%0d", f3, o), 5'd3,
                              reference(opLoad, f3, 1'b0, opA, {30'b0, off}));
               end
            end
         end
      end
      emit(encJ(21'd0, 5'd0));                  // Park in a tight loop
   endtask

   // ******************** Compare tasks
   task automatic checkWord(input string name, input logic [`QUARK_XLEN-1:0] expected,
                            input logic [`QUARK_XLEN-1:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic checkMask(input string name, input logic [3:0] expected,
                            input logic [3:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s mask: expected %b, actual %b", name, expected, actual);
         valueErrors++;
      end
   endtask

   // Compares each store as it leaves the core
   always @(posedge clk) begin : compareStores
      logic [31:0] lanes;
      if (!coreReset) begin
         checkIdx <= 0;
         sawFetch <= 1'b0;
      end else begin
         if (memReq.rstrb && !sawFetch) begin
            sawFetch <= 1'b1;
            checkWord("reset fetch", `QUARK_RESET_ADDR, memReq.addr);
         end
         if (memReq.wmask != 4'b0000) begin
            if (!sawFetch) begin
               $display("A store came before the first instruction fetch");
               storeErrors++;
            end else if (checkIdx >= expData.size()) begin
               $display("A store came after all expected results");
               storeErrors++;
            end else begin
               lanes = {{8{expMask[checkIdx][3]}}, {8{expMask[checkIdx][2]}},
                        {8{expMask[checkIdx][1]}}, {8{expMask[checkIdx][0]}}};
               checkWord({expName[checkIdx], " addr"}, expAddr[checkIdx], memReq.addr);
               checkMask(expName[checkIdx], expMask[checkIdx], memReq.wmask);
               checkWord(expName[checkIdx], expData[checkIdx] & lanes, memReq.wdata & lanes);
               checkIdx <= checkIdx + 1;
            end
         end
      end
   end

   // ******************** Run control
   task automatic waitResults(input string phase);
      int cycles;
      cycles = 0;
      while (checkIdx < expData.size() && cycles < 60000) begin
         @(posedge clk);
         cycles++;
      end
      if (checkIdx < expData.size()) begin
         $display("Timeout in %s run, %0d of %0d stores seen", phase, checkIdx, expData.size());
         timeouts++;
      end
   endtask

   initial begin
      int cycles;
      holdReset = 1'b0;
      busyOn    = 1'b0;
      void'($urandom(32'h4e67_ff9d));           // Seed the generator once
      buildProgram();
      for (cycles = 0; !porReset && cycles < 100; cycles++) begin
         @(posedge clk);
      end
      if (!porReset) begin
         $display("Timeout waiting for power-on reset to end");
         timeouts++;
      end
      waitResults("quiet memory");
      @(posedge clk);
      holdReset <= 1'b1;                        // Restart with back-pressure
      busyOn    <= 1'b1;
      @(posedge clk);
      buildProgram();
      repeat (16) @(posedge clk);
      holdReset <= 1'b0;
      repeat (2) @(posedge clk);
      waitResults("random busy");
      repeat (4) @(negedge clk);                // Let a stray store reach the compare
      $display("Errors: %0d value mismatches, %0d store faults, %0d timeouts",
               valueErrors, storeErrors, timeouts);
      if (valueErrors + storeErrors + timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: quarkCore.f
+incdir+logic
logic/quarkPkg.sv
logic/quarkDecoder.sv
logic/quarkRegFile.sv
logic/quarkAlu.sv
logic/quarkLoadStore.sv
logic/quarkControl.sv
logic/quarkCore.sv
test/tbClock.sv
test/quarkCoreTb.sv

// File: Makefile
# Verilator build and run of the quarkCore testbench
LOG = sim.log

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass is read from $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f quarkCore.f --top-module quarkCoreTb -o quarkCoreSim
	./obj_dir/quarkCoreSim | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
